/* rtl/conv_load_macros.svh */
`ifndef CONV_LOAD_MACROS_SVH
`define CONV_LOAD_MACROS_SVH

//////////////////////////////
// row geometry
//////////////////////////////

// pixels carried by one DDR word row
`define PIXELS_IN_ROW 32
`define PIXELS_IN_ROW_LOG2 5

// output rows per y tile, same as the row buffer count
`define TILE_ROWS 3

//////////////////////////////
// channel grouping
//////////////////////////////

// output channels per group, 8-bit mode then 1-bit mode
`define ROW_NUM_MODE0 64
`define ROW_NUM_MODE1 128

// two input channels share one word step
`define IFS_PER_WORD_LOG2 1

// field widths
`define DIM_W 16
`define CNT_W 8

`endif

/* rtl/conv_layer_pkg.sv */
`include "conv_load_macros.svh"

package conv_layer_pkg;

  // layer dimension or running index, counted from 1
  typedef logic [`DIM_W-1:0] dim_t;

  // chunk count or chunk size
  typedef logic [`CNT_W-1:0] cnt8_t;

  // power-of-two exponent
  typedef logic [3:0] log2_t;

  // split size per tile position, index as [y_pos][x_pos]
  // position codes are first=0, mid=1, last=2
  typedef cnt8_t [2:0][2:0] split_table_t;

  //////////////////////////////
  // layer description
  //////////////////////////////

  typedef struct packed {
    logic         mode;          // 0: 8-bit, 1: 1-bit
    logic [3:0]   s;             // stride, 1 or 2
    dim_t         of;
    dim_t         ox;
    dim_t         oy;
    dim_t         nif;
    log2_t        nif_log2;
    log2_t        ix_log2;
    dim_t         ddr_base;      // word address of the input tensor
    // ddr words per x chunk
    cnt8_t        x_words_first;
    cnt8_t        x_words_mid;
    cnt8_t        x_words_last;
    // input rows per y chunk
    cnt8_t        y_rows_first;
    cnt8_t        y_rows_mid;
    cnt8_t        y_rows_last;
    split_table_t split_table;
  } layer_cfg_t;

endpackage

/* rtl/conv_load_pkg.sv */
package conv_load_pkg;

  import conv_layer_pkg::*;

  //////////////////////////////
  // output tile position
  //////////////////////////////

  // first tile starts at 1, last tile runs past the edge
  typedef enum logic [1:0] {
    TILE_FIRST = 2'd0,
    TILE_MID   = 2'd1,
    TILE_LAST  = 2'd2
  } tile_pos_e;

  // where the current output tile sits in the layer
  typedef struct packed {
    dim_t      tile_x_start;
    dim_t      tile_y_start;
    tile_pos_e x_pos;
    tile_pos_e y_pos;
  } tile_state_t;

  //////////////////////////////
  // load indices
  //////////////////////////////

  // one ddr word: channel pair, input row, first pixel of the row chunk
  typedef struct packed {
    dim_t if_idx;
    dim_t row_idx;
    dim_t row_start_idx;
  } load_idx_t;

endpackage

/* rtl/output_tile_walker.sv */
`include "conv_load_macros.svh"

module output_tile_walker
  import conv_layer_pkg::*;
  import conv_load_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  layer_cfg_t  layer_cfg,
  input  logic        conv_load_input,
  input  logic        tile_done,
  output layer_cfg_t  cfg,
  output tile_state_t tile,
  output logic        f_wrap
);

  dim_t             tile_f_start;
  dim_t             tile_x_start;
  dim_t             tile_y_start;
  dim_t             row_num;
  logic [`DIM_W:0]  f_next;
  logic [`DIM_W:0]  x_next;
  logic [`DIM_W:0]  y_next;
  logic             x_wrap;
  logic             y_wrap;

  // first, last when the tile overruns the limit, mid otherwise
  function automatic tile_pos_e pos_of(dim_t start, dim_t span_m1, dim_t limit);
    logic [`DIM_W:0] end_pos;
    end_pos = {1'b0, start} + {1'b0, span_m1};
    if (start == dim_t'(1))
      pos_of = TILE_FIRST;
    else if (end_pos > {1'b0, limit})
      pos_of = TILE_LAST;
    else
      pos_of = TILE_MID;
  endfunction

  // layer config follows the input for as long as reset is high
  always_ff @(posedge clk)
  begin
    if (reset)
      cfg <= layer_cfg;
  end

  //////////////////////////////
  // channel group loop
  //////////////////////////////

  assign row_num = cfg.mode ? dim_t'(`ROW_NUM_MODE1) : dim_t'(`ROW_NUM_MODE0);
  assign f_next  = tile_f_start + row_num;
  // one term per pulse, so the group advances on every pulse
  assign f_wrap  = conv_load_input && (f_next > {1'b0, cfg.of});

  always_ff @(posedge clk)
  begin
    if (reset)
      tile_f_start <= dim_t'(1);
    else if (f_wrap)
      tile_f_start <= dim_t'(1);
    else if (conv_load_input)
      tile_f_start <= f_next[`DIM_W-1:0];
  end

  //////////////////////////////
  // x and y tile loops
  //////////////////////////////

  assign x_next = tile_x_start + dim_t'(`PIXELS_IN_ROW);
  assign y_next = tile_y_start + dim_t'(`TILE_ROWS);
  assign x_wrap = tile_done && (x_next > {1'b0, cfg.ox});
  // y only moves when a row of x tiles is finished
  assign y_wrap = x_wrap && (y_next > {1'b0, cfg.oy});

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tile_x_start <= dim_t'(1);
      tile_y_start <= dim_t'(1);
    end
    else if (tile_done)
    begin
      tile_x_start <= x_wrap ? dim_t'(1) : x_next[`DIM_W-1:0];
      if (y_wrap)
        tile_y_start <= dim_t'(1);
      else if (x_wrap)
        tile_y_start <= y_next[`DIM_W-1:0];
    end
  end

  always_comb
  begin
    tile.tile_x_start = tile_x_start;
    tile.tile_y_start = tile_y_start;
    tile.x_pos = pos_of(tile_x_start, dim_t'(`PIXELS_IN_ROW - 1), cfg.ox);
    tile.y_pos = pos_of(tile_y_start, dim_t'(`TILE_ROWS - 1), cfg.oy);
  end

endmodule

/* rtl/chunk_word_sequencer.sv */
`include "conv_load_macros.svh"

module chunk_word_sequencer
  import conv_layer_pkg::*;
  import conv_load_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  layer_cfg_t  cfg,
  input  tile_state_t tile,
  input  logic        conv_load_input,
  input  logic        f_wrap,
  input  logic        ddr_en,
  output logic        rd_en,
  output load_idx_t   idx,
  output logic        term_done,
  output logic        tile_done
);

  logic            active;
  logic            tile_locked;
  dim_t            if_idx;
  logic [`DIM_W:0] if_next;
  cnt8_t           chunk_cnt;
  dim_t            tile_cnt;
  cnt8_t           x_cnt;
  cnt8_t           y_cnt;
  cnt8_t           x_size;
  cnt8_t           y_size;
  cnt8_t           split_size;
  dim_t            tile_size;
  dim_t            ix_start;
  dim_t            iy_start;
  logic            col_close;
  logic            x_wrap;
  logic            tile_end;
  logic            term_end;

  // first input pixel or row of the tile for the layer stride
  function automatic dim_t stride_start(logic [3:0] s, dim_t start);
    if (s == 4'd2)
      stride_start = (start << 1) - dim_t'(1);
    else
      stride_start = start;
  endfunction

  //////////////////////////////
  // chunk geometry
  //////////////////////////////

  always_comb
  begin
    case (tile.x_pos)
      TILE_FIRST: x_size = cfg.x_words_first;
      TILE_LAST:  x_size = cfg.x_words_last;
      default:    x_size = cfg.x_words_mid;
    endcase
    case (tile.y_pos)
      TILE_FIRST: y_size = cfg.y_rows_first;
      TILE_LAST:  y_size = cfg.y_rows_last;
      default:    y_size = cfg.y_rows_mid;
    endcase
  end

  // columns loaded per term at this tile position
  assign split_size = cfg.split_table[tile.y_pos][tile.x_pos];
  // total columns in the tile
  assign tile_size  = dim_t'(x_size) * dim_t'(y_size);

  //////////////////////////////
  // word issue and loop ends
  //////////////////////////////

  assign rd_en     = active && ddr_en;
  assign if_next   = if_idx + dim_t'(2);
  // last channel pair of a column
  assign col_close = rd_en && (if_next > {1'b0, cfg.nif});
  assign tile_end  = col_close && (tile_cnt == tile_size);
  assign term_end  = col_close && ((chunk_cnt == split_size) || (tile_cnt == tile_size));
  assign x_wrap    = col_close && (x_cnt == x_size);
  assign term_done = term_end;
  assign tile_done = tile_end;

  // term runs from an accepted pulse to its last column
  always_ff @(posedge clk)
  begin
    if (reset)
      active <= 1'b0;
    else if (conv_load_input && !tile_locked)
      active <= 1'b1;
    else if (term_end)
      active <= 1'b0;
  end

  // loaded tile stays put until the channel groups come round again
  always_ff @(posedge clk)
  begin
    if (reset)
      tile_locked <= 1'b0;
    else if (tile_end)
      tile_locked <= 1'b1;
    else if (f_wrap)
      tile_locked <= 1'b0;
  end

  // inner channel loop, two channels per word
  always_ff @(posedge clk)
  begin
    if (reset)
      if_idx <= dim_t'(1);
    else if (col_close)
      if_idx <= dim_t'(1);
    else if (rd_en)
      if_idx <= if_next[`DIM_W-1:0];
  end

  // column counters, all step on a column close
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      chunk_cnt <= cnt8_t'(1);
      tile_cnt  <= dim_t'(1);
      x_cnt     <= cnt8_t'(1);
      y_cnt     <= cnt8_t'(1);
    end
    else if (col_close)
    begin
      chunk_cnt <= term_end ? cnt8_t'(1) : chunk_cnt + cnt8_t'(1);
      tile_cnt  <= tile_end ? dim_t'(1) : tile_cnt + dim_t'(1);
      x_cnt     <= x_wrap ? cnt8_t'(1) : x_cnt + cnt8_t'(1);
      // y row moves once per x chunk sweep
      if (x_wrap)
        y_cnt <= (y_cnt == y_size) ? cnt8_t'(1) : y_cnt + cnt8_t'(1);
    end
  end

  //////////////////////////////
  // load indices
  //////////////////////////////

  assign ix_start = stride_start(cfg.s, tile.tile_x_start);
  assign iy_start = stride_start(cfg.s, tile.tile_y_start);

  always_comb
  begin
    idx.if_idx        = if_idx;
    idx.row_idx       = (dim_t'(y_cnt) - dim_t'(1)) + iy_start;
    idx.row_start_idx = ((dim_t'(x_cnt) - dim_t'(1)) << `PIXELS_IN_ROW_LOG2) + ix_start;
  end

endmodule

/* rtl/ddr_input_address.sv */
`include "conv_load_macros.svh"

module ddr_input_address
  import conv_layer_pkg::*;
  import conv_load_pkg::*;
(
  input  layer_cfg_t cfg,
  input  load_idx_t  idx,
  output dim_t       rd_adr
);

  log2_t word_log2;
  log2_t row_shift;
  dim_t  row_term;
  dim_t  col_term;
  dim_t  if_term;

  //////////////////////////////
  // input tensor layout in ddr
  //////////////////////////////

  // words per pixel, log2
  assign word_log2 = cfg.nif_log2 - log2_t'(`IFS_PER_WORD_LOG2);
  // words per input row, log2
  assign row_shift = word_log2 + cfg.ix_log2 - log2_t'(`PIXELS_IN_ROW_LOG2);

  // whole rows before this one
  assign row_term = (idx.row_idx - dim_t'(1)) << row_shift;

  // pixels before the chunk start, converted to words
  assign col_term = ((idx.row_start_idx - dim_t'(1)) << word_log2) >> `PIXELS_IN_ROW_LOG2;

  // channel pair within the pixel
  assign if_term = (idx.if_idx - dim_t'(1)) >> `IFS_PER_WORD_LOG2;

  // wraps at 16 bits
  assign rd_adr = cfg.ddr_base + row_term + col_term + if_term;

endmodule

/* rtl/conv_load_input_controller.sv */
module conv_load_input_controller
  import conv_layer_pkg::*;
  import conv_load_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  layer_cfg_t layer_cfg,
  input  logic       conv_load_input,
  input  logic       ddr_en,
  output logic       rd_en,
  output dim_t       rd_adr,
  output load_idx_t  idx,
  output logic       term_done
);

  layer_cfg_t  cfg;
  tile_state_t tile;
  logic        f_wrap;
  logic        tile_done;

  //////////////////////////////
  // output tile walk
  //////////////////////////////

  output_tile_walker u_walker (
    .clk             (clk),
    .reset           (reset),
    .layer_cfg       (layer_cfg),
    .conv_load_input (conv_load_input),
    .tile_done       (tile_done),
    .cfg             (cfg),
    .tile            (tile),
    .f_wrap          (f_wrap)
  );

  // per term word sequence
  chunk_word_sequencer u_sequencer (
    .clk             (clk),
    .reset           (reset),
    .cfg             (cfg),
    .tile            (tile),
    .conv_load_input (conv_load_input),
    .f_wrap          (f_wrap),
    .ddr_en          (ddr_en),
    .rd_en           (rd_en),
    .idx             (idx),
    .term_done       (term_done),
    .tile_done       (tile_done)
  );

  // address valid alongside rd_en
  ddr_input_address u_address (
    .cfg    (cfg),
    .idx    (idx),
    .rd_adr (rd_adr)
  );

endmodule

/* dv/conv_load_model.svh */
`ifndef CONV_LOAD_MODEL_SVH
`define CONV_LOAD_MODEL_SVH

//////////////////////////////
// loop nest model state
//////////////////////////////

layer_cfg_t mcfg;
logic       act;
logic       locked;
// running indices, all start at 1
int         f_start;
int         tx;
int         ty;
int         if_i;
int         chunk_c;
int         tile_c;
int         x_c;
int         y_c;
int         layer_passes;
// chunk geometry of the current tile
int         cur_xs;
int         cur_ys;
int         cur_cols;
int         cur_split;
// expected dut outputs for this cycle
logic       exp_rd;
logic       exp_close;
logic       exp_term;
logic       exp_tile;
logic       exp_fwrap;
load_idx_t  exp_idx;
dim_t       exp_adr;

// 0 first, 2 last when the tile runs past the limit, 1 mid
function automatic int tile_pos(int start, int span, int limit);
  if (start == 1)
    return 0;
  if (start + span - 1 > limit)
    return 2;
  return 1;
endfunction

function automatic int by_pos(int pos, int first, int mid, int last);
  if (pos == 0)
    return first;
  if (pos == 2)
    return last;
  return mid;
endfunction

task automatic reset_model(input layer_cfg_t cfg);
  mcfg = cfg;
  act = 1'b0;
  locked = 1'b0;
  f_start = 1;
  tx = 1;
  ty = 1;
  if_i = 1;
  chunk_c = 1;
  tile_c = 1;
  x_c = 1;
  y_c = 1;
  layer_passes = 0;
endtask

// expected outputs from state and the inputs of this cycle
task automatic eval_model(input logic pulse, input logic ddr);
  int xp;
  int yp;
  int ixs;
  int iys;
  int row;
  int col;
  int wl2;
  int group;
  xp = tile_pos(tx, `PIXELS_IN_ROW, mcfg.ox);
  yp = tile_pos(ty, `TILE_ROWS, mcfg.oy);
  cur_xs = by_pos(xp, mcfg.x_words_first, mcfg.x_words_mid, mcfg.x_words_last);
  cur_ys = by_pos(yp, mcfg.y_rows_first, mcfg.y_rows_mid, mcfg.y_rows_last);
  cur_cols = cur_xs * cur_ys;
  cur_split = mcfg.split_table[yp][xp];
  group = mcfg.mode ? `ROW_NUM_MODE1 : `ROW_NUM_MODE0;
  exp_rd = act && ddr;
  // a column closes on its last channel pair
  exp_close = exp_rd && (if_i + 2 > mcfg.nif);
  exp_tile = exp_close && (tile_c == cur_cols);
  exp_term = exp_close && ((chunk_c == cur_split) || (tile_c == cur_cols));
  exp_fwrap = pulse && (f_start + group > mcfg.of);
  // input start of the tile, doubled for stride 2
  ixs = (mcfg.s == 2) ? 2 * tx - 1 : tx;
  iys = (mcfg.s == 2) ? 2 * ty - 1 : ty;
  row = y_c - 1 + iys;
  col = `PIXELS_IN_ROW * (x_c - 1) + ixs;
  exp_idx.if_idx = dim_t'(if_i);
  exp_idx.row_idx = dim_t'(row);
  exp_idx.row_start_idx = dim_t'(col);
  // words per pixel is nif / 2, words per row is that times ix / 32
  wl2 = mcfg.nif_log2 - 1;
  exp_adr = dim_t'(mcfg.ddr_base + ((row - 1) << (wl2 + mcfg.ix_log2 - 5))
                   + (((col - 1) << wl2) >> 5) + ((if_i - 1) >> 1));
endtask

// state step at the clock edge, uses the last eval_model results
task automatic advance_model(input logic pulse);
  int group;
  group = mcfg.mode ? `ROW_NUM_MODE1 : `ROW_NUM_MODE0;
  // lock is read before its own update
  if (pulse && !locked)
    act = 1'b1;
  else if (exp_term)
    act = 1'b0;
  if (exp_tile)
    locked = 1'b1;
  else if (exp_fwrap)
    locked = 1'b0;
  if (exp_close)
  begin
    if_i = 1;
    chunk_c = exp_term ? 1 : chunk_c + 1;
    tile_c = exp_tile ? 1 : tile_c + 1;
    if (x_c == cur_xs)
    begin
      x_c = 1;
      y_c = (y_c == cur_ys) ? 1 : y_c + 1;
    end
    else
      x_c = x_c + 1;
  end
  else if (exp_rd)
    if_i = if_i + 2;
  if (exp_fwrap)
    f_start = 1;
  else if (pulse)
    f_start = f_start + group;
  // output tile walk, x inner and y outer
  if (exp_tile)
  begin
    if (tx + `PIXELS_IN_ROW > mcfg.ox)
    begin
      tx = 1;
      if (ty + `TILE_ROWS > mcfg.oy)
      begin
        ty = 1;
        layer_passes = layer_passes + 1;
      end
      else
        ty = ty + `TILE_ROWS;
    end
    else
      tx = tx + `PIXELS_IN_ROW;
  end
endtask

`endif

/* dv/conv_load_tb.sv */
`include "conv_load_macros.svh"

module conv_load_tb
  import conv_layer_pkg::*;
  import conv_load_pkg::*;
();

  logic       clk;
  logic       reset;
  layer_cfg_t layer_cfg;
  logic       conv_load_input;
  logic       ddr_en;
  logic       rd_en;
  dim_t       rd_adr;
  load_idx_t  idx;
  logic       term_done;

  int         seed;
  // words seen in the running term
  int         term_words;
  // words seen over the running layer
  int         layer_words;
  logic       seen_term;
  layer_cfg_t next_cfg;

  `include "conv_load_model.svh"

  conv_load_input_controller dut0 (
    .clk             (clk),
    .reset           (reset),
    .layer_cfg       (layer_cfg),
    .conv_load_input (conv_load_input),
    .ddr_en          (ddr_en),
    .rd_en           (rd_en),
    .rd_adr          (rd_adr),
    .idx             (idx),
    .term_done       (term_done)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // error exits
  //////////////////////////////

  task automatic flag_mismatch(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_on_timeout(input string msg);
    $display("timeout at %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped on timeout");
  endtask

  function automatic int pick_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  //////////////////////////////
  // layer setup
  //////////////////////////////

  // legal unpadded layer, sizes from the tile geometry
  task automatic make_layer(input int stride, output layer_cfg_t cfg);
    int tail;
    int nl2;
    int last_x;
    int last_y;
    cfg = '0;
    cfg.mode = pick_below(2) == 1;
    cfg.s = 4'(stride);
    cfg.of = dim_t'(64 + pick_below(256));
    // odd tail gives a partial last x tile
    tail = (pick_below(2) == 1) ? 2 * pick_below(16) + 1 : 0;
    cfg.ox = dim_t'(32 * (1 + pick_below(3)) + tail);
    cfg.oy = dim_t'(3 + pick_below(8));
    nl2 = 2 + pick_below(3);
    cfg.nif = dim_t'(1 << nl2);
    cfg.nif_log2 = log2_t'(nl2);
    // input row padded up to a power of two
    cfg.ix_log2 = 4'd5;
    while ((1 << cfg.ix_log2) < stride * cfg.ox)
      cfg.ix_log2 = cfg.ix_log2 + 4'd1;
    cfg.ddr_base = dim_t'(pick_below(4096));
    last_x = cfg.ox - 32 * ((cfg.ox - 1) / 32);
    last_y = cfg.oy - 3 * ((cfg.oy - 1) / 3);
    cfg.x_words_first = cnt8_t'(stride);
    cfg.x_words_mid = cnt8_t'(stride);
    cfg.x_words_last = cnt8_t'((stride * last_x + 31) / 32);
    cfg.y_rows_first = cnt8_t'(3 * stride);
    cfg.y_rows_mid = cnt8_t'(3 * stride);
    cfg.y_rows_last = cnt8_t'(stride * last_y);
    for (int y = 0; y < 3; y++)
      for (int x = 0; x < 3; x++)
        cfg.split_table[y][x] = cnt8_t'(1 + pick_below(4));
  endtask

  // config is latched by the dut while reset is high
  task automatic reset_dut(input layer_cfg_t cfg);
    @(negedge clk);
    reset = 1'b1;
    layer_cfg = cfg;
    conv_load_input = 1'b0;
    ddr_en = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    reset_model(cfg);
  endtask

  //////////////////////////////
  // per cycle drive and check
  //////////////////////////////

  task automatic run_cycle(input logic pulse);
    @(negedge clk);
    conv_load_input = pulse;
    // ddr ready about 70% of cycles
    ddr_en = pick_below(10) < 7;
    #2;
    eval_model(pulse, ddr_en);
    assert (!(rd_en && !ddr_en))
    else flag_mismatch("rd_en high while ddr_en low");
    assert (rd_en === exp_rd)
    else flag_mismatch($sformatf("rd_en %b expected %b", rd_en, exp_rd));
    assert (term_done === exp_term)
    else flag_mismatch($sformatf("term_done %b expected %b", term_done, exp_term));
    if (exp_rd)
    begin
      assert (idx === exp_idx)
      else flag_mismatch($sformatf("idx if %0d row %0d col %0d expected %0d %0d %0d",
                                   idx.if_idx, idx.row_idx, idx.row_start_idx,
                                   exp_idx.if_idx, exp_idx.row_idx, exp_idx.row_start_idx));
      assert (rd_adr === exp_adr)
      else flag_mismatch($sformatf("rd_adr %h expected %h", rd_adr, exp_adr));
    end
    if (rd_en)
    begin
      term_words = term_words + 1;
      layer_words = layer_words + 1;
    end
    seen_term = term_done;
    advance_model(pulse);
  endtask

  // one pulse, then wait for the term end or confirm the lock
  task automatic run_term();
    logic accepted;
    int   cols;
    int   want;
    int   waited;
    accepted = !locked;
    term_words = 0;
    run_cycle(1'b1);
    if (accepted)
    begin
      // term covers the split size or what is left of the tile
      cols = cur_cols - tile_c + 1;
      if (cur_split < cols)
        cols = cur_split;
      want = cols * (mcfg.nif / 2);
      waited = 0;
      seen_term = 1'b0;
      while (!seen_term)
      begin
        run_cycle(1'b0);
        waited = waited + 1;
        if (!seen_term && waited > 4000)
          abort_on_timeout("term_done did not arrive after a term pulse");
      end
      assert (term_words == want)
      else flag_mismatch($sformatf("term had %0d words expected %0d", term_words, want));
    end
    else
    begin
      // locked tile, pulse loads nothing
      repeat (3) run_cycle(1'b0);
      assert (term_words == 0)
      else flag_mismatch($sformatf("%0d words after pulse on a loaded tile", term_words));
    end
  endtask

  // terms until the walk returns to the first tile
  task automatic run_layer();
    int pulses;
    int x_sum;
    int y_sum;
    int want_words;
    pulses = 0;
    layer_words = 0;
    // each tile loads once, so columns add up over first, mid and last tiles
    x_sum = 0;
    for (int x = 1; x <= mcfg.ox; x = x + `PIXELS_IN_ROW)
      x_sum = x_sum + by_pos(tile_pos(x, `PIXELS_IN_ROW, mcfg.ox),
                             mcfg.x_words_first, mcfg.x_words_mid, mcfg.x_words_last);
    y_sum = 0;
    for (int y = 1; y <= mcfg.oy; y = y + `TILE_ROWS)
      y_sum = y_sum + by_pos(tile_pos(y, `TILE_ROWS, mcfg.oy),
                             mcfg.y_rows_first, mcfg.y_rows_mid, mcfg.y_rows_last);
    want_words = x_sum * y_sum * (mcfg.nif / 2);
    while (layer_passes == 0)
    begin
      run_term();
      pulses = pulses + 1;
      if (layer_passes == 0 && pulses > 3000)
        abort_on_timeout("layer walk did not finish within the pulse limit");
    end
    assert (layer_words == want_words)
    else flag_mismatch($sformatf("layer issued %0d words expected %0d",
                                 layer_words, want_words));
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    layer_cfg = '0;
    conv_load_input = 1'b0;
    ddr_en = 1'b0;
    seed = 32'h9689d939;
    for (int n = 0; n < 8; n++)
    begin
      // strides alternate so both are covered
      make_layer(1 + (n % 2), next_cfg);
      reset_dut(next_cfg);
      // quiet until the first pulse
      repeat (4) run_cycle(1'b0);
      run_layer();
    end
    $display("Verification passed");
    $finish;
  end

endmodule

/* project.f */
+incdir+rtl
+incdir+dv
rtl/conv_layer_pkg.sv
rtl/conv_load_pkg.sv
rtl/output_tile_walker.sv
rtl/chunk_word_sequencer.sv
rtl/ddr_input_address.sv
rtl/conv_load_input_controller.sv
dv/conv_load_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module conv_load_tb \
  -f project.f -o conv_load_sim
./obj_dir/conv_load_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Verification passed" sim.log
echo "simulation passed"
